// File: rtl/cpu_cycle_monitor.sv
`include "rom_arbiter_consts.svh"

module cpu_cycle_monitor #(
  parameter int unsigned dead_timeout = `SNES_DEAD_TIMEOUT
) (
  input  logic CLK2,
  input  logic rst_n,
  input  logic snes_cpu_clk,
  input  logic snes_rom_hit,
  output logic free_slot,
  output logic snes_dead,
  output logic cpu_awake
);

  localparam int unsigned CNT_W = $clog2(dead_timeout + 1);

  logic [`CPU_CLK_HIST-1:0] clk_hist;   // Newest sample in bit 0
  logic                     cycle_start;
  logic                     cycle_end;
  logic [CNT_W-1:0]         idle_cnt;

  ////////////////////
  // CPU clock edges

  // Bit 0 is the synchronizer stage, older taps filter glitches
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      clk_hist    <= '0;
      cycle_start <= 1'b0;
      cycle_end   <= 1'b0;
    end else begin
      clk_hist    <= {clk_hist[`CPU_CLK_HIST-2:0], snes_cpu_clk};
      cycle_start <= (clk_hist[4:1] == 4'b0001);  // Rising edge
      cycle_end   <= (clk_hist[4:1] == 4'b1110);  // Falling edge
    end
  end

  // Bus is free right after a cycle, or for a whole cycle that misses ROM
  assign free_slot = cycle_end | (cycle_start & ~snes_rom_hit);

  ////////////////////
  // Dead console

  // Console starts out as off until its clock shows up
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      idle_cnt  <= CNT_W'(dead_timeout);
      snes_dead <= 1'b1;
    end else if (snes_cpu_clk) begin
      idle_cnt  <= '0;
      snes_dead <= 1'b0;
    end else begin
      if (idle_cnt != CNT_W'(dead_timeout)) begin
        idle_cnt <= idle_cnt + 1'b1;  // Saturates at the limit
      end
      if (idle_cnt >= CNT_W'(dead_timeout - 1)) begin
        snes_dead <= 1'b1;
      end
    end
  end

  // Single cycle, snes_dead drops on the next edge
  assign cpu_awake = snes_dead & snes_cpu_clk;

  // Timeout only runs on low samples
  a_dead_rise_low : assert property (
    @(posedge CLK2) disable iff (!rst_n)
    $rose(snes_dead) |-> !$past(snes_cpu_clk)
  );

endmodule

// File: rtl/mcu_request_latch.sv
module mcu_request_latch (
  input  logic                        CLK2,
  input  logic                        rst_n,
  input  logic                        mcu_req,
  input  logic                        mcu_write,
  input  rom_arbiter_pkg::snes_addr_t mcu_addr,
  input  rom_arbiter_pkg::byte_t      mcu_wdata,
  input  logic                        access_done,
  output logic                        mcu_ack,
  output logic                        rd_pend,
  output logic                        wr_pend,
  output rom_arbiter_pkg::snes_addr_t req_addr,
  output rom_arbiter_pkg::byte_t      req_wdata
);

  import rom_arbiter_pkg::*;

  logic req_q;
  logic accept;

  // New request only from a fully idle handshake
  assign accept = mcu_req & ~req_q & ~mcu_ack & ~rd_pend & ~wr_pend;

  ////////////////////
  // Handshake and pending flags
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      req_q   <= 1'b0;
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_ack <= 1'b0;
    end else begin
      req_q <= mcu_req;
      if (access_done) begin
        rd_pend <= 1'b0;
        wr_pend <= 1'b0;
        mcu_ack <= 1'b1;              // Read data already valid here
      end else begin
        if (accept) begin
          rd_pend <= ~mcu_write;
          wr_pend <= mcu_write;
        end
        if (mcu_ack && !mcu_req) begin
          mcu_ack <= 1'b0;            // MCU has let go, close the handshake
        end
      end
    end
  end

  // Held until the next accepted request
  always_ff @(posedge CLK2) begin
    if (accept) begin
      req_addr  <= mcu_addr;
      req_wdata <= mcu_wdata;
    end
  end

  ////////////////////
  // Checks
  a_one_pending : assert property (
    @(posedge CLK2) disable iff (!rst_n)
    rd_pend |-> !wr_pend
  );

  // Four-phase order, ack only drops once req is gone
  a_ack_after_req : assert property (
    @(posedge CLK2) disable iff (!rst_n)
    $fell(mcu_ack) |-> !$past(mcu_req)
  );

endmodule

// File: rtl/rom_access_fsm.sv
`include "rom_arbiter_consts.svh"

module rom_access_fsm (
  input  logic                        CLK2,
  input  logic                        rst_n,
  input  logic                        rd_pend,
  input  logic                        wr_pend,
  input  logic                        free_slot,
  input  logic                        snes_dead,
  input  logic                        cpu_awake,
  input  rom_arbiter_pkg::snes_addr_t req_addr,
  input  rom_arbiter_pkg::rom_word_t  rom_data_in,
  output logic                        access_done,
  output logic                        mcu_owns_bus,
  output logic                        mcu_wr_active,
  output rom_arbiter_pkg::byte_t      mcu_rdata
);

  import rom_arbiter_pkg::*;

  localparam int unsigned DLY_W = $clog2(`ROM_CYCLE_LEN + 1);

  arb_state_t       state;
  logic [DLY_W-1:0] delay;    // Clocks left in the address state
  logic             can_start;

  // Either a gap in SNES traffic or no SNES at all
  assign can_start = free_slot | snes_dead;

  ////////////////////
  // State machine
  always_ff @(posedge CLK2) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      delay <= '0;
    end else if (cpu_awake) begin
      // Console came back mid access, start over in a proper slot
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (can_start && rd_pend) begin
            state <= ST_MCU_RD_ADDR;
            delay <= DLY_W'(`ROM_CYCLE_LEN);
          end else if (can_start && wr_pend) begin
            state <= ST_MCU_WR_ADDR;
            delay <= DLY_W'(`ROM_CYCLE_LEN);
          end
        end
        ST_MCU_RD_ADDR: begin
          delay <= delay - 1'b1;
          if (delay == '0) begin
            state <= ST_MCU_RD_END;
          end
        end
        ST_MCU_WR_ADDR: begin
          delay <= delay - 1'b1;
          if (delay == '0) begin
            state <= ST_MCU_WR_END;
          end
        end
        ST_MCU_RD_END, ST_MCU_WR_END: state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  ////////////////////
  // Read data
  // Odd address sits in the low lane
  always_ff @(posedge CLK2) begin
    if (state == ST_MCU_RD_ADDR) begin
      mcu_rdata <= req_addr[0] ? rom_data_in[7:0] : rom_data_in[15:8];
    end
  end

  assign access_done   = (state == ST_MCU_RD_END) | (state == ST_MCU_WR_END);
  assign mcu_owns_bus  = (state == ST_MCU_RD_ADDR) | (state == ST_MCU_WR_ADDR);
  assign mcu_wr_active = (state == ST_MCU_WR_ADDR);

  a_state_onehot : assert property (
    @(posedge CLK2) disable iff (!rst_n)
    $onehot(state)
  );

endmodule

// File: rtl/rom_arbiter_consts.svh
`ifndef ROM_ARBITER_CONSTS_SVH
`define ROM_ARBITER_CONSTS_SVH

////////////////////
// Bus widths
`define SNES_ADDR_W 24        // Mapped byte address from the SNES side
`define ROM_ADDR_W 23         // PSRAM word address

////////////////////
// Timing
// Countdown start for one MCU access, 8 clocks in the address state
`define ROM_CYCLE_LEN 7

`define CPU_CLK_HIST 5        // Taps of the CPU clock history

// Idle CPU clock samples before the console counts as off, about 1 ms
`define SNES_DEAD_TIMEOUT 88000

`endif

// File: rtl/rom_arbiter_pkg.sv
`include "rom_arbiter_consts.svh"

package rom_arbiter_pkg;

  ////////////////////
  // Address and data
  typedef logic [`SNES_ADDR_W-1:0] snes_addr_t;     // Byte address
  typedef logic [`ROM_ADDR_W-1:0]  rom_word_addr_t; // Word address on the PSRAM
  typedef logic [7:0]              byte_t;
  typedef logic [15:0]             rom_word_t;      // Both lanes of the PSRAM bus

  ////////////////////
  // Arbiter FSM, one-hot
  typedef enum logic [4:0] {
    ST_IDLE        = 5'b00001,
    ST_MCU_RD_ADDR = 5'b00010,
    ST_MCU_RD_END  = 5'b00100,
    ST_MCU_WR_ADDR = 5'b01000,
    ST_MCU_WR_END  = 5'b10000
  } arb_state_t;

endpackage

// File: rtl/rom_bus_mux.sv
module rom_bus_mux (
  input  rom_arbiter_pkg::snes_addr_t     snes_addr,
  input  logic                            snes_write,     // Active low
  input  logic                            snes_cpu_clk,
  input  logic                            snes_rom_hit,
  input  logic                            snes_writable,
  input  rom_arbiter_pkg::byte_t          snes_wdata,
  input  rom_arbiter_pkg::snes_addr_t     req_addr,
  input  rom_arbiter_pkg::byte_t          req_wdata,
  input  logic                            mcu_owns_bus,
  input  logic                            mcu_wr_active,
  input  rom_arbiter_pkg::rom_word_t      rom_data_in,
  output rom_arbiter_pkg::rom_word_addr_t rom_addr,
  output logic                            rom_bhe,        // Active low
  output logic                            rom_ble,        // Active low
  output logic                            rom_we,         // Active low
  output logic                            rom_data_oe,
  output rom_arbiter_pkg::rom_word_t      rom_data_out,
  output rom_arbiter_pkg::byte_t          snes_rdata
);

  import rom_arbiter_pkg::*;

  snes_addr_t sel_addr;
  logic       addr_odd;
  logic       snes_wr_hit;
  byte_t      wr_byte;

  ////////////////////
  // Address and lanes
  assign sel_addr = mcu_owns_bus ? req_addr : snes_addr;
  assign addr_odd = sel_addr[0];
  assign rom_addr = sel_addr[$bits(snes_addr_t)-1:1];

  // Odd byte goes to the low lane, even byte to the high lane
  assign rom_bhe = addr_odd;
  assign rom_ble = ~addr_odd;

  ////////////////////
  // Write path

  // SNES writes only land in the second half of its bus cycle
  assign snes_wr_hit = ~mcu_owns_bus & snes_rom_hit & snes_writable
                     & snes_cpu_clk & ~snes_write;

  assign rom_we      = ~(mcu_wr_active | snes_wr_hit);
  assign rom_data_oe = mcu_wr_active | snes_wr_hit;

  // Same byte on both lanes, the lane enables pick the target
  assign wr_byte      = mcu_wr_active ? req_wdata : snes_wdata;
  assign rom_data_out = {wr_byte, wr_byte};

  // SNES read pass-through
  assign snes_rdata = addr_odd ? rom_data_in[7:0] : rom_data_in[15:8];

endmodule

// File: rtl/snes_rom_arbiter.sv
`include "rom_arbiter_consts.svh"

module snes_rom_arbiter #(
  parameter int unsigned dead_timeout = `SNES_DEAD_TIMEOUT
) (
  input  logic                            CLK2,
  input  logic                            rst_n,
  // SNES side
  input  rom_arbiter_pkg::snes_addr_t     snes_addr,
  input  logic                            snes_write,
  input  logic                            snes_cpu_clk,
  input  logic                            snes_rom_hit,
  input  logic                            snes_writable,
  input  rom_arbiter_pkg::byte_t          snes_wdata,
  output rom_arbiter_pkg::byte_t          snes_rdata,
  // MCU side
  input  logic                            mcu_req,
  input  logic                            mcu_write,
  input  rom_arbiter_pkg::snes_addr_t     mcu_addr,
  input  rom_arbiter_pkg::byte_t          mcu_wdata,
  output logic                            mcu_ack,
  output rom_arbiter_pkg::byte_t          mcu_rdata,
  // PSRAM
  output rom_arbiter_pkg::rom_word_addr_t rom_addr,
  output logic                            rom_bhe,
  output logic                            rom_ble,
  output logic                            rom_we,
  output logic                            rom_data_oe,
  output rom_arbiter_pkg::rom_word_t      rom_data_out,
  input  rom_arbiter_pkg::rom_word_t      rom_data_in
);

  import rom_arbiter_pkg::*;

  logic       free_slot;
  logic       snes_dead;
  logic       cpu_awake;
  logic       rd_pend;
  logic       wr_pend;
  logic       access_done;
  logic       mcu_owns_bus;
  logic       mcu_wr_active;
  snes_addr_t req_addr;
  byte_t      req_wdata;

  cpu_cycle_monitor #(.dead_timeout(dead_timeout)) u_cpu_cycle_monitor (
    .CLK2, .rst_n, .snes_cpu_clk, .snes_rom_hit,
    .free_slot, .snes_dead, .cpu_awake
  );

  mcu_request_latch u_mcu_request_latch (
    .CLK2, .rst_n, .mcu_req, .mcu_write, .mcu_addr, .mcu_wdata, .access_done,
    .mcu_ack, .rd_pend, .wr_pend, .req_addr, .req_wdata
  );

  rom_access_fsm u_rom_access_fsm (
    .CLK2, .rst_n, .rd_pend, .wr_pend, .free_slot, .snes_dead, .cpu_awake,
    .req_addr, .rom_data_in,
    .access_done, .mcu_owns_bus, .mcu_wr_active, .mcu_rdata
  );

  rom_bus_mux u_rom_bus_mux (
    .snes_addr, .snes_write, .snes_cpu_clk, .snes_rom_hit, .snes_writable,
    .snes_wdata, .req_addr, .req_wdata, .mcu_owns_bus, .mcu_wr_active,
    .rom_data_in,
    .rom_addr, .rom_bhe, .rom_ble, .rom_we, .rom_data_oe, .rom_data_out,
    .snes_rdata
  );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the arbiter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module snes_rom_arbiter_tb \
  -f snes_rom_arbiter.f --Mdir obj_dir -o sim_top > build.log 2>&1 \
  && ./obj_dir/sim_top > sim.log 2>&1 \
  || { echo "Build or run failed, see build.log and sim.log"; exit 1; }

grep -q "Simulation PASSED" sim.log \
  && echo "Testbench passed" \
  || { echo "Testbench failed, see sim.log"; exit 1; }

// File: sim/arbiter_vectors.txt
# name op addr data mode expected   (hex values, expected byte unused for mcu_wr)
# mode: dead, running, wake (dead then CPU clock starts mid access), protect (snes_writable low)
wr_dead      mcu_wr  000010 5a dead    00
rd_dead      mcu_rd  000010 00 dead    5a
lane_even_wr mcu_wr  000100 11 dead    00
lane_odd_wr  mcu_wr  000101 22 dead    00
lane_even_rd mcu_rd  000100 00 dead    11
lane_odd_rd  mcu_rd  000101 00 dead    22
run_wr0      mcu_wr  000222 c3 running 00
run_wr1      mcu_wr  000223 3c running 00
run_rd0      mcu_rd  000222 00 running c3
run_rd1      mcu_rd  000223 00 running 3c
run_wr2      mcu_wr  0007fe 96 running 00
run_rd2      mcu_rd  0007fe 00 running 96
snes_wr0     snes_wr 000300 a5 running a5
snes_rd0     snes_rd 000300 00 running a5
snes_wr1     snes_wr 000301 7e running 7e
snes_ro      snes_wr 000300 3c protect a5
snes_rd1     snes_rd 000300 00 running a5
mcu_rd_snes  mcu_rd  000301 00 dead    7e
wake_wr      mcu_wr  000444 e1 dead    00
wake_rd      mcu_rd  000444 00 wake    e1
after_wake   mcu_rd  000101 00 running 22

// File: sim/snes_rom_arbiter_tb.sv
module snes_rom_arbiter_tb;

  localparam int DEAD_TO = 20;
  localparam int SETTLE  = 48;   // One more CPU cycle plus a whole access

  logic        CLK2 = 1'b0;
  logic        rst_n, snes_write, snes_cpu_clk, snes_rom_hit, snes_writable;
  logic        mcu_req, mcu_write, mcu_ack;
  logic [23:0] snes_addr, mcu_addr;
  logic [7:0]  snes_wdata, snes_rdata, mcu_wdata, mcu_rdata;
  logic [22:0] rom_addr;
  logic        rom_bhe, rom_ble, rom_we, rom_data_oe;
  logic [15:0] rom_data_out, rom_data_in;

  string       v_name [0:63];
  string       v_op   [0:63];
  string       v_mode [0:63];
  logic [23:0] v_addr [0:63];
  logic [7:0]  v_data [0:63];
  logic [7:0]  v_exp  [0:63];
  int          nvec = 0, errors = 0, test_errs = 0, failed_tests = 0;
  int          cycles = 0, limit = 100, ack_rises = 0, half_left = 0;
  logic        ack_seen = 1'b0;
  logic [1:0]  cpu_mode = 2'd0;   // 0 held low, 1 running, 2 held high

  snes_rom_arbiter #(.dead_timeout(DEAD_TO)) u_snes_rom_arbiter (.*);
  tb_psram_model u_psram (.*);

  always #2 CLK2 = ~CLK2;

  ////////////////////
  // CPU clock and monitors
  always @(posedge CLK2) begin
    #1;
    case (cpu_mode)
      2'd0: snes_cpu_clk = 1'b0;
      2'd2: snes_cpu_clk = 1'b1;
      default: begin
        if (half_left == 0) begin
          snes_cpu_clk = ~snes_cpu_clk;
          half_left = 7 + int'($urandom % 8);   // Half period of 8 to 15
        end else half_left--;
      end
    endcase
  end

  always @(posedge CLK2) begin
    if (mcu_ack && !ack_seen) ack_rises++;
    ack_seen = mcu_ack;
    cycles++;
    if (cycles >= limit) begin
      $display("Timeout: cycle limit of %0d reached, a handshake never finished", limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic check_value(input string test, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("** Error %s: expected %0h, actual %0h", test, exp, act);
      errors++;
      test_errs++;
    end
  endtask

  task automatic load_vectors();
    int fd, cnt;
    logic [8*128-1:0] line;
    logic [8*32-1:0]  nm, op, md;
    logic [23:0]      a;
    logic [7:0]       d, e;
    fd = $fopen("sim/arbiter_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file sim/arbiter_vectors.txt");
    end else begin
      while (!$feof(fd) && nvec < 64) begin
        line = '0;
        void'($fgets(line, fd));
        cnt = $sscanf(line, "%s %s %h %h %s %h", nm, op, a, d, md, e);
        if (cnt == 6) begin
          v_name[nvec] = string'(nm);
          v_op[nvec]   = string'(op);
          v_mode[nvec] = string'(md);
          v_addr[nvec] = a;
          v_data[nvec] = d;
          v_exp[nvec]  = e;
          nvec++;
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////
  // Operations
  task automatic mcu_access(input int i);
    int lat, rises;
    @(posedge CLK2);
    if (v_mode[i] != "running") cpu_mode = 2'd0;
    else if (cpu_mode != 2'd1) cpu_mode = 2'd1;
    if (v_mode[i] != "running") repeat (DEAD_TO + 4) @(posedge CLK2);  // Let the console die
    rises = ack_rises;
    #1;
    mcu_addr  = v_addr[i];
    mcu_wdata = v_data[i];
    mcu_write = (v_op[i] == "mcu_wr");
    mcu_req   = 1'b1;
    lat = 0;
    if (v_mode[i] == "wake") begin
      repeat (4) @(posedge CLK2);   // Access under way, then the console wakes
      lat += 4;
      cpu_mode = 2'd2;
      repeat (3) @(posedge CLK2);
      lat += 3;
      cpu_mode  = 2'd1;
      half_left = 7;
    end
    while (!mcu_ack) begin
      @(posedge CLK2);
      #1;
      lat++;
    end
    if (v_mode[i] == "dead") check_value({v_name[i], "_latency"}, 1, 32'(lat <= 12));
    // A restarted access cannot finish within the dead console latency
    if (v_mode[i] == "wake") check_value({v_name[i], "_restart"}, 1, 32'(lat > 12));
    if (!mcu_write) check_value(v_name[i], 32'(v_exp[i]), 32'(mcu_rdata));
    #1 mcu_req = 1'b0;
    while (mcu_ack) @(posedge CLK2);
    repeat (SETTLE) @(posedge CLK2);  // A repeated access would ack again in here
    #1 check_value({v_name[i], "_ack_count"}, 1, ack_rises - rises);
  endtask

  task automatic snes_access(input int i);
    @(posedge CLK2);
    cpu_mode = 2'd0;
    #1;
    snes_addr     = v_addr[i];
    snes_wdata    = v_data[i];
    snes_writable = (v_mode[i] != "protect");
    snes_write    = (v_op[i] != "snes_wr");
    repeat (2) @(posedge CLK2);
    cpu_mode = 2'd2;                 // Write lands while the CPU clock is high
    repeat (4) @(posedge CLK2);
    cpu_mode = 2'd0;
    #1;
    snes_write    = 1'b1;
    snes_writable = 1'b1;
    @(posedge CLK2);
    check_value(v_name[i], 32'(v_exp[i]), 32'(snes_rdata));
  endtask

  initial begin
    void'($urandom(32'he80a5055));
    rst_n = 1'b0;
    {snes_write, snes_rom_hit, snes_writable} = 3'b111;
    snes_cpu_clk = 1'b0;
    {mcu_req, mcu_write} = 2'b00;
    snes_addr = '0;
    mcu_addr  = '0;
    snes_wdata = '0;
    mcu_wdata  = '0;
    load_vectors();
    limit = nvec * 200 + 100;
    repeat (2) @(posedge CLK2);
    #1 rst_n = 1'b1;
    @(posedge CLK2);
    check_value("reset_ack", 0, 32'(mcu_ack));
    check_value("reset_we", 1, 32'(rom_we));
    check_value("reset_oe", 0, 32'(rom_data_oe));
    $display("test %-14s %s", "reset", (test_errs == 0) ? "ok" : "failed");
    if (test_errs != 0) failed_tests++;
    if (nvec == 0) begin
      $display("No test vectors were read, nothing else to run");
      errors++;
    end
    for (int i = 0; i < nvec; i++) begin
      test_errs = 0;
      if (v_op[i] == "mcu_wr" || v_op[i] == "mcu_rd") mcu_access(i);
      else snes_access(i);
      $display("test %-14s %s", v_name[i], (test_errs == 0) ? "ok" : "failed");
      if (test_errs != 0) failed_tests++;
    end
    $display("Tests: %0d, failed: %0d, check errors: %0d", nvec + 1, failed_tests, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: sim/tb_psram_model.sv
module tb_psram_model (
  input  logic        CLK2,
  input  logic [22:0] rom_addr,
  input  logic        rom_bhe,      // Active low, high lane
  input  logic        rom_ble,      // Active low, low lane
  input  logic        rom_we,       // Active low
  input  logic [15:0] rom_data_out,
  output logic [15:0] rom_data_in
);

  logic [15:0] mem [0:1023];   // 2 KiB window is enough for the tests
  logic [9:0]  word_idx;

  assign word_idx    = rom_addr[9:0];
  assign rom_data_in = mem[word_idx];

  // Fill depends on every index bit
  initial begin
    for (int i = 0; i < 1024; i++) begin
      mem[i] = {8'(i) ^ 8'h5a, {2'(i >> 8), 6'(i)} ^ 8'h3c};
    end
  end

  always @(posedge CLK2) begin
    if (!rom_we) begin
      if (!rom_bhe) mem[word_idx][15:8] <= rom_data_out[15:8];
      if (!rom_ble) mem[word_idx][7:0]  <= rom_data_out[7:0];
    end
  end

endmodule

// File: snes_rom_arbiter.f
+incdir+rtl
rtl/rom_arbiter_pkg.sv
rtl/cpu_cycle_monitor.sv
rtl/mcu_request_latch.sv
rtl/rom_access_fsm.sv
rtl/rom_bus_mux.sv
rtl/snes_rom_arbiter.sv
sim/tb_psram_model.sv
sim/snes_rom_arbiter_tb.sv
